/* hdl/addr_map_regs.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module addr_map_regs
  import xbar_pkg::*;
(
  input  logic       clk,
  input  logic       rstn,
  input  logic       cfg_valid,
  input  logic [1:0] cfg_idx,
  input  map_entry_t cfg_entry,
  input  logic       busy,
  output logic       cfg_ready,
  output map_table_t map
);

  // Entry 0 sits in the low bits
  localparam map_table_t RESET_MAP = {
    `SLV2_BASE, `SLV2_MASK,
    `SLV1_BASE, `SLV1_MASK,
    `SLV0_BASE, `SLV0_MASK
  };

  logic cfg_fire;
  logic idx_ok;

  // No map change while a write is in flight
  assign cfg_ready = !busy;
  assign cfg_fire  = cfg_valid && cfg_ready;

  // Index 3 has no entry, handshake still completes
  assign idx_ok = (cfg_idx < `NUM_SLAVES);

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      map <= RESET_MAP;
    end else if (cfg_fire && idx_ok) begin
      map[cfg_idx] <= cfg_entry;
    end
  end

endmodule

/* hdl/aw_route.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module aw_route
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  logic                          clk,
  input  logic                          rstn,
  input  map_table_t                    map,
  input  aw_chan_t                      m_aw,
  input  logic                          m_aw_valid,
  output logic                          m_aw_ready,
  output aw_chan_t [`NUM_SLAVES-1:0]    s_aw,
  output logic [`NUM_SLAVES-1:0]        s_aw_valid,
  input  logic [`NUM_SLAVES-1:0]        s_aw_ready,
  input  logic                          w_done,
  input  logic                          b_done,
  output slv_sel_t                      aw_sel,
  output logic                          aw_fire,
  output slv_sel_t                      tgt_sel,
  output axi_id_t                       tgt_id,
  output logic                          busy,
  output route_state_t                  state
);

  route_state_t state_next;

  // Walk down so the lowest matching index wins
  always_comb begin
    aw_sel = SEL_NONE;
    for (int i = `NUM_SLAVES - 1; i >= 0; i--) begin
      if ((m_aw.addr & map[i].mask) == map[i].base) begin
        aw_sel = slv_sel_t'(i);
      end
    end
  end

  always_comb begin
    s_aw       = '0;
    s_aw_valid = '0;
    m_aw_ready = 1'b0;
    if (state == ROUTE_IDLE) begin
      if (aw_sel == SEL_NONE) begin
        // Unmatched address is taken locally
        m_aw_ready = 1'b1;
      end else begin
        for (int i = 0; i < `NUM_SLAVES; i++) begin
          if (aw_sel == slv_sel_t'(i)) begin
            s_aw[i]       = m_aw;
            s_aw_valid[i] = m_aw_valid;
            m_aw_ready    = s_aw_ready[i];
          end
        end
      end
    end
  end

  assign aw_fire = m_aw_valid && m_aw_ready;

  // A pending AW also freezes the map so its slave cannot change
  assign busy = (state != ROUTE_IDLE) || m_aw_valid;

  always_comb begin
    state_next = state;
    case (state)
      ROUTE_IDLE: begin
        if (aw_fire) begin
          // Last beat may ride along on the fast path
          state_next = w_done ? ROUTE_RESP : ROUTE_DATA;
        end
      end
      ROUTE_DATA: begin
        if (w_done) begin
          state_next = ROUTE_RESP;
        end
      end
      ROUTE_RESP: begin
        if (b_done) begin
          state_next = ROUTE_IDLE;
        end
      end
      default: state_next = ROUTE_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state   <= ROUTE_IDLE;
      tgt_sel <= SEL_NONE;
    end else begin
      state <= state_next;
      if (aw_fire) begin
        tgt_sel <= aw_sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      tgt_id <= m_aw.id;
    end
  end

endmodule

/* hdl/axi_pkg.sv */
`include "axi_params.svh"

package axi_pkg;

  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
  typedef logic [`AXI_ID_BITS-1:0]   axi_id_t;
  // Beat count is len + 1
  typedef logic [`AXI_LEN_BITS-1:0]  axi_len_t;
  typedef logic [1:0]                axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  typedef struct packed {
    axi_addr_t addr;
    axi_id_t   id;
    axi_len_t  len;
  } aw_chan_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } w_chan_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } b_chan_t;

endpackage

/* hdl/axi_wr_xbar.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module axi_wr_xbar
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  logic                         clk,
  input  logic                         rstn,
  // Master
  input  aw_chan_t                     m_aw,
  input  logic                         m_aw_valid,
  output logic                         m_aw_ready,
  input  w_chan_t                      m_w,
  input  logic                         m_w_valid,
  output logic                         m_w_ready,
  output b_chan_t                      m_b,
  output logic                         m_b_valid,
  input  logic                         m_b_ready,
  // Slaves
  output aw_chan_t [`NUM_SLAVES-1:0]   s_aw,
  output logic [`NUM_SLAVES-1:0]       s_aw_valid,
  input  logic [`NUM_SLAVES-1:0]       s_aw_ready,
  output w_chan_t [`NUM_SLAVES-1:0]    s_w,
  output logic [`NUM_SLAVES-1:0]       s_w_valid,
  input  logic [`NUM_SLAVES-1:0]       s_w_ready,
  input  b_chan_t [`NUM_SLAVES-1:0]    s_b,
  input  logic [`NUM_SLAVES-1:0]       s_b_valid,
  output logic [`NUM_SLAVES-1:0]       s_b_ready,
  // Map configuration
  input  logic                         cfg_valid,
  output logic                         cfg_ready,
  input  logic [1:0]                   cfg_idx,
  input  map_entry_t                   cfg_entry
);

  map_table_t   map;
  slv_sel_t     aw_sel;
  logic         aw_fire;
  slv_sel_t     tgt_sel;
  axi_id_t      tgt_id;
  logic         busy;
  route_state_t state;
  logic         w_done;
  logic         b_done;

  addr_map_regs u_map (
    .clk       (clk),
    .rstn      (rstn),
    .cfg_valid (cfg_valid),
    .cfg_idx   (cfg_idx),
    .cfg_entry (cfg_entry),
    .busy      (busy),
    .cfg_ready (cfg_ready),
    .map       (map)
  );

  aw_route u_aw (
    .clk        (clk),
    .rstn       (rstn),
    .map        (map),
    .m_aw       (m_aw),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .s_aw       (s_aw),
    .s_aw_valid (s_aw_valid),
    .s_aw_ready (s_aw_ready),
    .w_done     (w_done),
    .b_done     (b_done),
    .aw_sel     (aw_sel),
    .aw_fire    (aw_fire),
    .tgt_sel    (tgt_sel),
    .tgt_id     (tgt_id),
    .busy       (busy),
    .state      (state)
  );

  w_route u_w (
    .state     (state),
    .aw_sel    (aw_sel),
    .aw_fire   (aw_fire),
    .tgt_sel   (tgt_sel),
    .m_w       (m_w),
    .m_w_valid (m_w_valid),
    .m_w_ready (m_w_ready),
    .s_w       (s_w),
    .s_w_valid (s_w_valid),
    .s_w_ready (s_w_ready),
    .w_done    (w_done)
  );

  b_route u_b (
    .clk       (clk),
    .rstn      (rstn),
    .state     (state),
    .tgt_sel   (tgt_sel),
    .tgt_id    (tgt_id),
    .s_b       (s_b),
    .s_b_valid (s_b_valid),
    .s_b_ready (s_b_ready),
    .m_b       (m_b),
    .m_b_valid (m_b_valid),
    .m_b_ready (m_b_ready),
    .b_done    (b_done)
  );

endmodule

/* hdl/b_route.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module b_route
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  logic                         clk,
  input  logic                         rstn,
  input  route_state_t                 state,
  input  slv_sel_t                     tgt_sel,
  input  axi_id_t                      tgt_id,
  input  b_chan_t [`NUM_SLAVES-1:0]    s_b,
  input  logic [`NUM_SLAVES-1:0]       s_b_valid,
  output logic [`NUM_SLAVES-1:0]       s_b_ready,
  output b_chan_t                      m_b,
  output logic                         m_b_valid,
  input  logic                         m_b_ready,
  output logic                         b_done
);

  logic b_taken;
  logic resp_phase;

  // One response per write, even if the phase were to linger
  assign resp_phase = (state == ROUTE_RESP) && !b_taken;

  always_comb begin
    m_b       = '0;
    m_b_valid = 1'b0;
    s_b_ready = '0;
    if (resp_phase) begin
      if (tgt_sel == SEL_NONE) begin
        m_b.id    = tgt_id;
        m_b.resp  = RESP_DECERR;
        m_b_valid = 1'b1;
      end else begin
        // Other slaves' B valids are ignored
        for (int i = 0; i < `NUM_SLAVES; i++) begin
          if (tgt_sel == slv_sel_t'(i)) begin
            m_b          = s_b[i];
            m_b_valid    = s_b_valid[i];
            s_b_ready[i] = m_b_ready;
          end
        end
      end
    end
  end

  assign b_done = m_b_valid && m_b_ready;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      b_taken <= 1'b0;
    end else if (b_done) begin
      b_taken <= 1'b1;
    end else if (state != ROUTE_RESP) begin
      b_taken <= 1'b0;
    end
  end

endmodule

/* hdl/w_route.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module w_route
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  route_state_t                 state,
  input  slv_sel_t                     aw_sel,
  input  logic                         aw_fire,
  input  slv_sel_t                     tgt_sel,
  input  w_chan_t                      m_w,
  input  logic                         m_w_valid,
  output logic                         m_w_ready,
  output w_chan_t [`NUM_SLAVES-1:0]    s_w,
  output logic [`NUM_SLAVES-1:0]       s_w_valid,
  input  logic [`NUM_SLAVES-1:0]       s_w_ready,
  output logic                         w_done
);

  logic     fast_path;
  logic     slow_path;
  slv_sel_t w_sel;

  // W beside the AW handshake follows the live decode
  assign fast_path = aw_fire;
  // Later beats use the target latched at AW
  assign slow_path = (state == ROUTE_DATA);
  assign w_sel     = fast_path ? aw_sel : tgt_sel;

  always_comb begin
    s_w       = '0;
    s_w_valid = '0;
    m_w_ready = 1'b0;
    if (fast_path || slow_path) begin
      if (w_sel == SEL_NONE) begin
        // Local sink drops every beat
        m_w_ready = 1'b1;
      end else begin
        for (int i = 0; i < `NUM_SLAVES; i++) begin
          if (w_sel == slv_sel_t'(i)) begin
            s_w[i]       = m_w;
            s_w_valid[i] = m_w_valid;
            m_w_ready    = s_w_ready[i];
          end
        end
      end
    end
  end

  assign w_done = m_w_valid && m_w_ready && m_w.last;

endmodule

/* hdl/xbar_pkg.sv */
`include "axi_params.svh"

package xbar_pkg;

  import axi_pkg::*;

  // SEL_NONE is the local decode error target
  typedef enum logic [1:0] {
    SEL_S0   = 2'd0,
    SEL_S1   = 2'd1,
    SEL_S2   = 2'd2,
    SEL_NONE = 2'd3
  } slv_sel_t;

  typedef enum logic [1:0] {
    ROUTE_IDLE = 2'd0,
    ROUTE_DATA = 2'd1,
    ROUTE_RESP = 2'd2
  } route_state_t;

  typedef struct packed {
    axi_addr_t base;
    axi_addr_t mask;
  } map_entry_t;

  typedef map_entry_t [`NUM_SLAVES-1:0] map_table_t;

endpackage

/* include/axi_params.svh */
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_ID_BITS   4
`define AXI_LEN_BITS  4

`define NUM_SLAVES 3

// Address map after reset
`define SLV0_BASE 32'h0000_0000
`define SLV0_MASK 32'hFFFF_0000
`define SLV1_BASE 32'h0001_0000
`define SLV1_MASK 32'hFFFF_0000
`define SLV2_BASE 32'h1000_0000
`define SLV2_MASK 32'hF000_0000

`endif

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f verilog.f --top-module axi_wr_xbar_tb -o sim_tb \
  > build.log 2>&1 &&
  ./obj_dir/sim_tb > sim.log 2>&1 ||
  { echo "build or simulation did not complete"; cat build.log sim.log; exit 1; }
grep -q "^PASS: all tests$" sim.log && echo "simulation passed" ||
  { cat sim.log; exit 1; }

/* verification/axi_wr_xbar_sva.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module axi_wr_xbar_sva
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input logic                       clk,
  input logic                       rstn,
  input aw_chan_t [`NUM_SLAVES-1:0] s_aw,
  input logic [`NUM_SLAVES-1:0]     s_aw_valid,
  input logic [`NUM_SLAVES-1:0]     s_aw_ready,
  input w_chan_t [`NUM_SLAVES-1:0]  s_w,
  input logic [`NUM_SLAVES-1:0]     s_w_valid,
  input logic [`NUM_SLAVES-1:0]     s_w_ready,
  input b_chan_t                    m_b,
  input logic                       m_b_valid,
  input logic                       m_b_ready,
  input route_state_t               state
);

  a_aw_one: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_aw_valid))
    else $error("more than one s_aw_valid high");
  a_w_one: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_w_valid))
    else $error("more than one s_w_valid high");

  // Slave side valid and payload hold until the handshake
  for (genvar i = 0; i < `NUM_SLAVES; i++) begin : g_slv
    a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
      s_aw_valid[i] && !s_aw_ready[i] |=> s_aw_valid[i] && $stable(s_aw[i]))
      else $error("s_aw_valid dropped or s_aw changed before its handshake");
    a_w_hold: assert property (@(posedge clk) disable iff (!rstn)
      s_w_valid[i] && !s_w_ready[i] |=> s_w_valid[i] && $stable(s_w[i]))
      else $error("s_w_valid dropped or s_w changed before its handshake");
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
    m_b_valid && !m_b_ready |=> m_b_valid && $stable(m_b))
    else $error("m_b dropped or changed before its handshake");

  a_b_phase: assert property (@(posedge clk) disable iff (!rstn)
    m_b_valid |-> state == ROUTE_RESP)
    else $error("m_b_valid high outside the response phase");

endmodule

bind axi_wr_xbar axi_wr_xbar_sva sva0 (
  .clk(clk), .rstn(rstn),
  .s_aw(s_aw), .s_aw_valid(s_aw_valid), .s_aw_ready(s_aw_ready),
  .s_w(s_w), .s_w_valid(s_w_valid), .s_w_ready(s_w_ready),
  .m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready), .state(state)
);

/* verification/axi_wr_xbar_tb.sv */
`timescale 1ns/10ps
`include "axi_params.svh"

module axi_wr_xbar_tb
  import axi_pkg::*;
  import xbar_pkg::*;
();

  localparam int NUM_WRITES = 50;
  localparam int MAX_BEATS  = 8;
  localparam int LIMIT      = NUM_WRITES * (MAX_BEATS + 20);

  logic                         clk;
  logic                         rstn;
  aw_chan_t                     m_aw;
  logic                         m_aw_valid;
  logic                         m_aw_ready;
  w_chan_t                      m_w;
  logic                         m_w_valid;
  logic                         m_w_ready;
  b_chan_t                      m_b;
  logic                         m_b_valid;
  logic                         m_b_ready;
  aw_chan_t [`NUM_SLAVES-1:0]   s_aw;
  logic [`NUM_SLAVES-1:0]       s_aw_valid;
  logic [`NUM_SLAVES-1:0]       s_aw_ready;
  w_chan_t [`NUM_SLAVES-1:0]    s_w;
  logic [`NUM_SLAVES-1:0]       s_w_valid;
  logic [`NUM_SLAVES-1:0]       s_w_ready;
  b_chan_t [`NUM_SLAVES-1:0]    s_b;
  logic [`NUM_SLAVES-1:0]       s_b_valid;
  logic [`NUM_SLAVES-1:0]       s_b_ready;
  logic                         cfg_valid;
  logic                         cfg_ready;
  logic [1:0]                   cfg_idx;
  map_entry_t                   cfg_entry;

  integer    seed = 32'h6388;
  integer    slv_seed = 32'h6388 ^ 32'h0000_5a5a;
  int        errors;
  int        tests;
  int        failed;
  int        cycles;
  logic      full_ready;
  logic      b_seen;
  axi_addr_t mbase[3];
  axi_addr_t mmask[3];
  // What the slave side saw, written by the monitor only
  aw_chan_t  obs_aw[3];
  int        aw_cnt[3];
  int        vld_cnt[3];
  int        last_cnt[3];
  axi_id_t   slv_id[3];
  logic [2:0] sb_hs;
  w_chan_t   w_obs[$];
  int        w_slv[$];
  int        mb_cnt;

  axi_wr_xbar dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, a handshake never completed", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  always @(negedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (s_aw_valid[i] || s_w_valid[i]) begin
        vld_cnt[i]++;
      end
      if (s_aw_valid[i] && s_aw_ready[i]) begin
        obs_aw[i] = s_aw[i];
        slv_id[i] = s_aw[i].id;
        aw_cnt[i]++;
      end
      if (s_w_valid[i] && s_w_ready[i]) begin
        w_obs.push_back(s_w[i]);
        w_slv.push_back(i);
        if (s_w[i].last) begin
          last_cnt[i]++;
        end
      end
      sb_hs[i] = s_b_valid[i] && s_b_ready[i];
    end
    if (m_b_valid && m_b_ready) begin
      mb_cnt++;
    end
  end

  // Slave models, one B per received last beat
  initial begin
    logic [31:0] r;
    int          b_sent[3];
    s_aw_ready = '0;
    s_w_ready  = '0;
    s_b        = '0;
    s_b_valid  = '0;
    b_sent     = '{0, 0, 0};
    forever begin
      @(posedge clk);
      #2;
      for (int i = 0; i < 3; i++) begin
        r = $random(slv_seed);
        s_aw_ready[i] = full_ready || r[0] || r[1];
        s_w_ready[i]  = full_ready || r[2] || r[3];
        if (s_b_valid[i] && sb_hs[i]) begin
          s_b_valid[i] = 1'b0;
        end else if (!s_b_valid[i] && last_cnt[i] > b_sent[i] && r[4]) begin
          s_b[i].id    = slv_id[i];
          s_b[i].resp  = RESP_OKAY;
          s_b_valid[i] = 1'b1;
          b_sent[i]++;
        end
      end
    end
  end

  function automatic int expected_slave(input axi_addr_t addr);
    for (int i = 0; i < 3; i++) begin
      if ((addr & mmask[i]) == mbase[i]) begin
        return i;
      end
    end
    return 3;
  endfunction

  function automatic axi_addr_t pick_addr(input int sel);
    logic [31:0] r;
    r = $random(seed);
    return mbase[sel] | (r & ~mmask[sel]);
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic w_chan_t make_beat(input axi_data_t d, input axi_strb_t s, input logic l);
    w_chan_t b;
    b.data = d;
    b.strb = s;
    b.last = l;
    return b;
  endfunction

  task automatic do_write(input axi_addr_t addr, input logic fast, input logic bp);
    aw_chan_t    aw;
    axi_data_t   data_q[MAX_BEATS];
    axi_strb_t   strb_q[MAX_BEATS];
    axi_resp_t   exp_resp;
    logic [31:0] r;
    int          n;
    int          exp;
    int          sent;
    int          delay;
    int          w0;
    int          mb0;
    int          aw0[3];
    int          v0[3];
    logic        aw_done;
    logic        b_got;
    logic        aw_hs;
    logic        w_hs;
    r = $random(seed);
    aw.addr  = addr;
    aw.id    = r[3:0];
    aw.len   = {1'b0, r[6:4]};
    n        = int'(r[6:4]) + 1;
    delay    = int'(r[9:8]);
    exp      = expected_slave(addr);
    exp_resp = (exp == 3) ? RESP_DECERR : RESP_OKAY;
    for (int k = 0; k < n; k++) begin
      data_q[k] = $random(seed);
      r = $random(seed);
      strb_q[k] = r[3:0];
    end
    w0  = w_obs.size();
    mb0 = mb_cnt;
    for (int i = 0; i < 3; i++) begin
      aw0[i] = aw_cnt[i];
      v0[i]  = vld_cnt[i];
    end
    sent    = 0;
    aw_done = 1'b0;
    b_got   = 1'b0;
    b_seen  = 1'b0;
    @(posedge clk);
    #2;
    m_aw       = aw;
    m_aw_valid = 1'b1;
    if (fast) begin
      m_w       = make_beat(data_q[0], strb_q[0], n == 1);
      m_w_valid = 1'b1;
    end
    while (!b_got) begin
      @(negedge clk);
      aw_hs = m_aw_valid && m_aw_ready;
      w_hs  = m_w_valid && m_w_ready;
      assert (!(aw_done && m_aw_ready)) else begin
        $display("AW ready came back before the B handshake of the previous write");
        errors++;
      end
      assert (!(w_hs && !aw_done && !aw_hs)) else begin
        $display("W beat accepted before its AW");
        errors++;
      end
      if (m_b_valid && m_b_ready) begin
        b_got  = 1'b1;
        b_seen = 1'b1;
        assert (m_b.resp == exp_resp) else begin
          $display("** Error m_b.resp: got %h, expected %h", m_b.resp, exp_resp);
          errors++;
        end
        assert (m_b.id == aw.id) else begin
          $display("** Error m_b.id: got %h, expected %h", m_b.id, aw.id);
          errors++;
        end
      end
      if (aw_hs) begin
        aw_done = 1'b1;
      end
      if (w_hs) begin
        sent++;
      end
      @(posedge clk);
      #2;
      r = $random(seed);
      m_b_ready = !bp || r[0];
      if (aw_hs) begin
        m_aw_valid = 1'b0;
      end
      if (w_hs) begin
        m_w_valid = (sent < n);
        if (sent < n) begin
          m_w = make_beat(data_q[sent], strb_q[sent], sent == n - 1);
        end
      end else if (aw_done && !m_w_valid && sent == 0) begin
        if (delay == 0) begin
          m_w       = make_beat(data_q[0], strb_q[0], n == 1);
          m_w_valid = 1'b1;
        end else begin
          delay--;
        end
      end
    end
    assert (sent == n && mb_cnt - mb0 == 1) else begin
      $display("Master sent %0d of %0d beats and saw %0d B handshakes", sent, n, mb_cnt - mb0);
      errors++;
    end
    for (int i = 0; i < 3; i++) begin
      if (i == exp) begin
        assert (aw_cnt[i] - aw0[i] == 1 && obs_aw[i] == aw) else begin
          $display("** Error s_aw[%0d]: got %h, expected %h", i, obs_aw[i], aw);
          errors++;
        end
      end else begin
        assert (vld_cnt[i] == v0[i]) else begin
          $display("Slave %0d saw a valid for a write routed elsewhere", i);
          errors++;
        end
      end
    end
    if (exp < 3) begin
      assert (w_obs.size() - w0 == n) else begin
        $display("Slave %0d received %0d beats, expected %0d", exp, w_obs.size() - w0, n);
        errors++;
      end
      for (int k = 0; k < n && w0 + k < w_obs.size(); k++) begin
        assert (w_slv[w0 + k] == exp &&
                w_obs[w0 + k] == make_beat(data_q[k], strb_q[k], k == n - 1)) else begin
          $display("** Error s_w[%0d]: got %h, expected %h", w_slv[w0 + k], w_obs[w0 + k],
                   make_beat(data_q[k], strb_q[k], k == n - 1));
          errors++;
        end
      end
    end
  endtask

  task automatic cfg_write(input int idx, input axi_addr_t base, input axi_addr_t mask,
                           input logic after_b);
    @(posedge clk);
    #2;
    cfg_idx        = idx[1:0];
    cfg_entry.base = base;
    cfg_entry.mask = mask;
    cfg_valid      = 1'b1;
    @(negedge clk);
    while (!cfg_ready) begin
      @(negedge clk);
    end
    assert (!after_b || b_seen) else begin
      $display("Map write accepted while a write was outstanding");
      errors++;
    end
    @(posedge clk);
    #2;
    cfg_valid  = 1'b0;
    mbase[idx] = base;
    mmask[idx] = mask;
  endtask

  task automatic report(input string name, input int e0);
    tests++;
    if (errors != e0) begin
      failed++;
    end
    $display("%s: %s", name, (errors == e0) ? "ok" : "failed");
  endtask

  initial begin
    int          e0;
    logic [31:0] r;
    rstn       = 1'b0;
    m_aw       = '0;
    m_aw_valid = 1'b0;
    m_w        = '0;
    m_w_valid  = 1'b0;
    m_b_ready  = 1'b0;
    cfg_valid  = 1'b0;
    cfg_idx    = '0;
    cfg_entry  = '0;
    full_ready = 1'b1;
    mbase = '{`SLV0_BASE, `SLV1_BASE, `SLV2_BASE};
    mmask = '{`SLV0_MASK, `SLV1_MASK, `SLV2_MASK};
    repeat (5) @(posedge clk);
    #2;
    rstn = 1'b1;

    e0 = errors;
    for (int k = 0; k < 12; k++) begin
      do_write(pick_addr(k % 3), coin(), 1'b0);
    end
    report("reset map routing", e0);

    e0 = errors;
    for (int k = 0; k < 8; k++) begin
      do_write(pick_addr(k % 3), k % 2 == 0, 1'b0);
    end
    report("fast and late W", e0);

    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      r = $random(seed);
      do_write(32'h8000_0000 | (r & 32'h0FFF_FFFF), coin(), 1'b0);
    end
    report("decode error", e0);

    e0 = errors;
    full_ready = 1'b0;
    for (int k = 0; k < 20; k++) begin
      do_write(pick_addr(k % 3), coin(), 1'b1);
    end
    full_ready = 1'b1;
    report("back-pressure", e0);

    e0 = errors;
    cfg_write(0, 32'h2000_0000, 32'hF000_0000, 1'b0);
    cfg_write(1, 32'h3000_0000, 32'hFFF0_0000, 1'b0);
    do_write(pick_addr(0), coin(), 1'b0);
    do_write(pick_addr(1), coin(), 1'b0);
    // Old slave 0 window now decodes to nothing
    do_write(32'h0000_1234, coin(), 1'b0);
    fork
      do_write(pick_addr(2), 1'b0, 1'b1);
      cfg_write(2, 32'h4000_0000, 32'hF000_0000, 1'b1);
    join
    do_write(pick_addr(2), coin(), 1'b0);
    do_write(32'h1000_0040, coin(), 1'b0);
    report("map reconfiguration", e0);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hdl/axi_pkg.sv
hdl/xbar_pkg.sv
hdl/addr_map_regs.sv
hdl/aw_route.sv
hdl/w_route.sv
hdl/b_route.sv
hdl/axi_wr_xbar.sv
verification/axi_wr_xbar_sva.sv
verification/axi_wr_xbar_tb.sv
